// ==== build.f ====
+incdir+test
rtl/gelu_pkg.sv
rtl/fixed_signed_cast.sv
rtl/gelu_coef_rom.sv
rtl/gelu_lane.sv
rtl/fixed_gelu.sv
rtl/stream_skid.sv
rtl/gelu_top.sv
test/tb_gelu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_gelu_top -f build.f -o tb_gelu_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_gelu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== test/gelu_model.svh ====
`ifndef GELU_MODEL_SVH
`define GELU_MODEL_SVH

// expected gelu value of one lane, taken from the table and the region rules
function automatic gelu_data_t gelu_expect(input gelu_data_t x);
  longint xv;
  longint x_int;
  longint acc;
  longint q;
  longint max_v;
  longint min_v;
  int     idx;
  gelu_coef_t k;

  xv    = longint'(x);
  x_int = xv >>> FRAC_W;
  max_v = (longint'(1) <<< (DATA_W - 1)) - 1;
  min_v = -(longint'(1) <<< (DATA_W - 1));

  // right tail passes through, left tail is zero
  if (x_int >= 4) begin
    return x;
  end
  if (x_int <= -4) begin
    return '0;
  end

  idx = int'((x_int + 4) & 7);
  k   = GELU_LUT[idx];

  // a*x^2 + b*x + c with every term at 2*FRAC_W + COEF_FRAC fraction bits
  acc = longint'($signed(k.a)) * xv * xv;
  acc = acc + ((longint'($signed(k.b)) * xv) <<< FRAC_W);
  acc = acc + (longint'($signed(k.c)) <<< (2 * FRAC_W));

  // floor back to the sample format, then clamp
  q = acc >>> (ACC_FRAC - FRAC_W);
  if (q > max_v) begin
    q = max_v;
  end else if (q < min_v) begin
    q = min_v;
  end
  return gelu_data_t'(q);
endfunction

`endif

// ==== test/tb_gelu_top.sv ====
`timescale 1ns/1ns

module tb_gelu_top;

  import gelu_pkg::*;

  `include "gelu_model.svh"

  localparam int LANES       = 4;
  localparam int QUAD_BEATS  = 500;
  localparam int TAIL_BEATS  = 300;
  localparam int LAT_BEATS   = 50;
  localparam int FLOW_BEATS  = 1000;
  localparam int TOTAL_BEATS = QUAD_BEATS + TAIL_BEATS + LAT_BEATS + FLOW_BEATS;
  localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 200;
  // pipeline plus skid hold at most four beats, three cycles deep
  localparam int DRAIN_LIMIT = 16;

  typedef gelu_data_t [LANES-1:0] beat_t;

  logic  clk;
  logic  rst;
  beat_t in_data;
  logic  in_valid;
  logic  in_ready;
  beat_t out_data;
  logic  out_valid;
  logic  out_ready;

  int    seed;
  int    cycle;
  int    errors;
  int    checks;
  int    in_count;
  int    out_count;
  bit    in_fire;
  bit    check_latency;
  beat_t exp_q[$];
  int    acc_q[$];

  gelu_top #(
    .LANES(LANES)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // **************************************************
  // monitor, scoreboard and timeout
  // **************************************************

  always @(posedge clk) begin
    beat_t exp_beat;
    int    acc_cycle;
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle);
      $display("** FAIL **");
      $finish;
    end else if (rst) begin
      in_fire = 1'b0;
    end else begin
      in_fire = in_valid && in_ready;
      if (in_fire) begin
        for (int i = 0; i < LANES; i++) begin
          exp_beat[i] = gelu_expect(in_data[i]);
        end
        exp_q.push_back(exp_beat);
        acc_q.push_back(cycle);
        in_count++;
      end
      if (out_valid && out_ready) begin
        out_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("output beat at %0t ns arrived with no input beat waiting", $time);
        end else begin
          exp_beat  = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          for (int i = 0; i < LANES; i++) begin
            check_value($sformatf("lane %0d", i), int'(out_data[i]), int'(exp_beat[i]));
          end
          if (check_latency) begin
            check_value("latency in cycles", cycle - acc_cycle, 3);
          end
        end
      end
    end
  end

  // **************************************************
  // stimulus
  // **************************************************

  // mode 0 covers the quadratic segments, mode 1 the tails, mode 2 any byte
  function automatic gelu_data_t gen_sample(input int mode);
    int v;
    case (mode)
      0: v = ($random(seed) & 63) - 32;
      1: begin
        v = 32 + ({$random(seed)} % 96);
        if ($random(seed) & 1) begin
          v = -v - 1;
        end
      end
      default: v = $random(seed) & 255;
    endcase
    return gelu_data_t'(v);
  endfunction

  task automatic run_stream(input int n_beats, input int mode, input bit flow_rand);
    int start;
    start = in_count;
    while (in_count - start < n_beats) begin
      @(negedge clk);
      if (flow_rand) begin
        out_ready = ($random(seed) & 3) != 0;
      end
      // a beat still waiting for ready stays as it is
      if (!(in_valid && !in_fire)) begin
        if (in_count - start < n_beats && (!flow_rand || ($random(seed) & 1))) begin
          in_valid = 1'b1;
          for (int i = 0; i < LANES; i++) begin
            in_data[i] = gen_sample(mode);
          end
        end else begin
          in_valid = 1'b0;
        end
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    out_ready = 1'b1;
    waited    = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d beats never came out of the DUT", exp_q.size());
      exp_q.delete();
      acc_q.delete();
    end
    // a few idle cycles so a stray beat would show up
    repeat (4) @(negedge clk);
    check_value("out_valid when idle", int'(out_valid), 0);
  endtask

  task automatic report_test(input int num, input string name, input int err0, input int out0);
    $display("test %0d %s done: %0d beats out, %0d errors",
             num, name, out_count - out0, errors - err0);
  endtask

  initial begin
    int err0;
    int out0;
    seed          = 40;
    clk           = 1'b0;
    rst           = 1'b1;
    in_data       = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    in_count      = 0;
    out_count     = 0;
    in_fire       = 1'b0;
    check_latency = 1'b0;

    repeat (4) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    out0 = out_count;
    @(negedge clk);
    check_value("out_valid after reset", int'(out_valid), 0);
    check_value("in_ready after reset", int'(in_ready), 1);
    report_test(1, "reset state", err0, out0);

    err0 = errors;
    out0 = out_count;
    run_stream(QUAD_BEATS, 0, 1'b0);
    wait_drain();
    report_test(2, "quadratic region", err0, out0);

    err0 = errors;
    out0 = out_count;
    run_stream(TAIL_BEATS, 1, 1'b0);
    wait_drain();
    report_test(3, "passthrough and zero", err0, out0);

    err0 = errors;
    out0 = out_count;
    check_latency = 1'b1;
    run_stream(LAT_BEATS, 2, 1'b0);
    wait_drain();
    check_latency = 1'b0;
    report_test(4, "latency", err0, out0);

    err0 = errors;
    out0 = out_count;
    run_stream(FLOW_BEATS, 2, 1'b1);
    wait_drain();
    report_test(5, "back-pressure", err0, out0);

    $display("%0d beats in, %0d beats out, %0d checks, %0d errors",
             in_count, out_count, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== rtl/gelu_top.sv ====
`timescale 1ns/1ns

module gelu_top #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  gelu_pkg::gelu_data_t [LANES-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output gelu_pkg::gelu_data_t [LANES-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready
);

  import gelu_pkg::*;

  // compute pipeline to skid buffer
  gelu_data_t [LANES-1:0] mid_data;
  logic                   mid_valid;
  logic                   mid_ready;

  fixed_gelu #(
    .LANES(LANES)
  ) gelu0 (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .mid_data (mid_data),
    .mid_valid(mid_valid),
    .mid_ready(mid_ready)
  );

  // cuts the out_ready path back into the pipeline enable
  stream_skid #(
    .LANES(LANES)
  ) skid0 (
    .clk      (clk),
    .rst      (rst),
    .mid_data (mid_data),
    .mid_valid(mid_valid),
    .mid_ready(mid_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

// ==== rtl/stream_skid.sv ====
`timescale 1ns/1ns

module stream_skid #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  gelu_pkg::gelu_data_t [LANES-1:0] mid_data,
  input  logic                             mid_valid,
  output logic                             mid_ready,
  output gelu_pkg::gelu_data_t [LANES-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready
);

  import gelu_pkg::*;

  gelu_data_t [LANES-1:0] ovf_data;
  logic                   ovf_valid;
  logic                   push;
  logic                   main_free;

  assign push      = mid_valid && mid_ready;
  // main register empties or hands its beat over this cycle
  assign main_free = !out_valid || out_ready;

  // **************************************************
  // control
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ovf_valid <= 1'b0;
      mid_ready <= 1'b1;
    end else if (main_free) begin
      // overflow drains first, it holds the older beat
      out_valid <= ovf_valid || push;
      ovf_valid <= 1'b0;
      mid_ready <= 1'b1;
    end else if (push) begin
      ovf_valid <= 1'b1;
      mid_ready <= 1'b0;
    end
  end

  // **************************************************
  // data
  // **************************************************

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (ovf_valid) begin
        out_data <= ovf_data;
      end else if (push) begin
        out_data <= mid_data;
      end
    end else if (push) begin
      ovf_data <= mid_data;
    end
  end

endmodule

// ==== rtl/fixed_gelu.sv ====
`timescale 1ns/1ns

module fixed_gelu #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  gelu_pkg::gelu_data_t [LANES-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output gelu_pkg::gelu_data_t [LANES-1:0] mid_data,
  output logic                             mid_valid,
  input  logic                             mid_ready
);

  logic valid_s1;
  logic valid_s2;
  logic advance;

  // **************************************************
  // valid chain
  // **************************************************

  // move when the last stage is empty or being taken downstream
  assign advance  = !valid_s2 || mid_ready;
  assign in_ready = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else if (advance) begin
      valid_s1 <= in_valid;
      valid_s2 <= valid_s1;
    end
  end

  assign mid_valid = valid_s2;

  // **************************************************
  // lanes
  // **************************************************

  // every lane shares one advance, so all lanes hold together
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    gelu_lane lane (
      .clk    (clk),
      .rst    (rst),
      .advance(advance),
      .x      (in_data[i]),
      .y      (mid_data[i])
    );
  end

endmodule

// ==== rtl/gelu_lane.sv ====
`timescale 1ns/1ns

module gelu_lane (
  input  logic                clk,
  input  logic                rst,
  input  logic                advance,
  input  gelu_pkg::gelu_data_t x,
  output gelu_pkg::gelu_data_t y
);

  import gelu_pkg::*;

  localparam int INT_W = DATA_W - FRAC_W;

  gelu_data_t x_s1;
  gelu_data_t x_s2;
  logic [2:0] seg_idx;
  gelu_coef_t coef;

  logic signed [2*DATA_W-1:0] x_sq;
  logic signed [ACC_W-1:0]    ax2;
  logic signed [ACC_W-1:0]    bx;
  logic signed [ACC_W-1:0]    c_ext;
  logic signed [ACC_W-1:0]    poly;
  logic signed [ACC_W-1:0]    result;
  logic signed [INT_W-1:0]    x_int;

  // **************************************************
  // stage 1 and stage 2 sample registers
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      x_s1 <= '0;
      x_s2 <= '0;
    end else if (advance) begin
      x_s1 <= x;
      x_s2 <= x_s1;
    end
  end

  // low three integer bits, offset so -4 maps to entry 0
  assign seg_idx = x_s1[FRAC_W+2:FRAC_W] + 3'd4;

  gelu_coef_rom rom0 (
    .clk    (clk),
    .advance(advance),
    .index  (seg_idx),
    .coef   (coef)
  );

  // **************************************************
  // stage 2 polynomial with all terms at ACC_FRAC
  // **************************************************

  assign x_sq  = x_s2 * x_s2;
  assign ax2   = $signed(coef.a) * x_sq;
  assign bx    = ($signed(coef.b) * x_s2) <<< FRAC_W;
  assign c_ext = $signed(coef.c) <<< (2 * FRAC_W);
  assign poly  = ax2 + bx + c_ext;

  assign x_int = $signed(x_s2[DATA_W-1:FRAC_W]);

  always_comb begin
    result = poly;
    if (x_int >= 4) begin
      // gelu(x) is x on the far right of the curve
      result = ACC_W'(x_s2) <<< (FRAC_W + COEF_FRAC);
    end else if (x_int <= -4) begin
      result = '0;
    end
  end

  fixed_signed_cast #(
    .IN_W    (ACC_W),
    .IN_FRAC (ACC_FRAC),
    .OUT_W   (DATA_W),
    .OUT_FRAC(FRAC_W)
  ) cast0 (
    .in_data (result),
    .out_data(y)
  );

endmodule

// ==== rtl/gelu_coef_rom.sv ====
`timescale 1ns/1ns

module gelu_coef_rom (
  input  logic                clk,
  input  logic                advance,
  input  logic [2:0]          index,
  output gelu_pkg::gelu_coef_t coef
);

  import gelu_pkg::*;

  // registered read, so coef lines up with the stage 2 sample
  always_ff @(posedge clk) begin
    if (advance) begin
      coef <= GELU_LUT[index];
    end
  end

endmodule

// ==== rtl/fixed_signed_cast.sv ====
`timescale 1ns/1ns

module fixed_signed_cast #(
  parameter int IN_W     = 33,
  parameter int IN_FRAC  = 20,
  parameter int OUT_W    = 8,
  parameter int OUT_FRAC = 3
) (
  input  logic signed [IN_W-1:0]  in_data,
  output logic signed [OUT_W-1:0] out_data
);

  localparam int SHIFT = IN_FRAC - OUT_FRAC;

  logic signed [IN_W-1:0] shifted;
  // everything above the output msb, including the msb itself
  logic [IN_W-OUT_W:0] upper;

  // arithmetic shift drops the low bits, so this rounds toward -inf
  assign shifted = in_data >>> SHIFT;
  assign upper   = shifted[IN_W-1:OUT_W-1];

  always_comb begin
    if (upper == '0 || upper == '1) begin
      out_data = shifted[OUT_W-1:0];
    end else if (shifted[IN_W-1]) begin
      // most negative value
      out_data = {1'b1, {(OUT_W - 1){1'b0}}};
    end else begin
      // most positive value
      out_data = {1'b0, {(OUT_W - 1){1'b1}}};
    end
  end

endmodule

// ==== rtl/gelu_pkg.sv ====
package gelu_pkg;

  // **************************************************
  // sample and coefficient formats
  // **************************************************

  localparam int DATA_W    = 8;
  localparam int FRAC_W    = 3;
  localparam int COEF_W    = 16;
  localparam int COEF_FRAC = 14;
  localparam int SEG_N     = 8;

  // a*x^2 is the widest term, one extra bit keeps the three-term sum
  localparam int ACC_W    = COEF_W + 2 * DATA_W + 1;
  localparam int ACC_FRAC = 2 * FRAC_W + COEF_FRAC;

  typedef logic signed [DATA_W-1:0] gelu_data_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] a;
    logic signed [COEF_W-1:0] b;
    logic signed [COEF_W-1:0] c;
  } gelu_coef_t;

  // **************************************************
  // piecewise quadratic table
  // **************************************************

  // index is integer part plus 4, wrapped to 3 bits
  localparam gelu_coef_t GELU_LUT [SEG_N] = '{
    // [-4, -3)
    '{a: 16'hffaf, b: 16'hfd91, c: 16'hfb4c},
    // [-3, -2)
    '{a: 16'hfda5, b: 16'hf1a8, c: 16'he9e1},
    // [-2, -1)
    '{a: 16'hff64, b: 16'hf68f, c: 16'hecc9},
    // [-1, 0)
    '{a: 16'h1329, b: 16'h1ca9, c: 16'hffaf},
    // [0, 1)
    '{a: 16'h135b, b: 16'h2325, c: 16'hffb9},
    // [1, 2)
    '{a: 16'hff80, b: 16'h491b, c: 16'hed09},
    // [2, 3)
    '{a: 16'hfd9d, b: 16'h4e7d, c: 16'he9b4},
    // [3, 4)
    '{a: 16'hffad, b: 16'h427f, c: 16'hfb31}
  };

endpackage
